/* design/sdram_csr_pkg.sv */
/*
 * SDRAM CSR bus definitions
 * Bus widths, register map offsets and the internal access word
 * passed from the bus slave to the register banks.
 */

package sdram_csr_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int CSR_ADDR_W = 16;             // Byte address width
    localparam int CSR_DATA_W = 32;             // Bus word width
    localparam int CSR_DEC_W  = 8;              // Low address bits used by decode

    typedef logic [CSR_DATA_W-1:0] csr_data_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------
    localparam logic [CSR_DEC_W-1:0] OFS_CTRL      = 8'h00; // Start, self refresh, LMR
    localparam logic [CSR_DEC_W-1:0] OFS_OPMODE    = 8'h04; // Mode register image
    localparam logic [CSR_DEC_W-1:0] OFS_CONFIG    = 8'h08; // Precharge after read

    // 0x0c to 0x1c reserved
    localparam logic [CSR_DEC_W-1:0] OFS_T_DLY_RST = 8'h20;
    localparam logic [CSR_DEC_W-1:0] OFS_T_RASMIN  = 8'h64;
    localparam logic [CSR_DEC_W-1:0] OFS_T_RC      = 8'h6c;
    localparam logic [CSR_DEC_W-1:0] OFS_T_RCD     = 8'h70;
    localparam logic [CSR_DEC_W-1:0] OFS_T_REF     = 8'h74;
    localparam logic [CSR_DEC_W-1:0] OFS_T_RFC     = 8'h78;
    localparam logic [CSR_DEC_W-1:0] OFS_T_RP      = 8'h80;
    localparam logic [CSR_DEC_W-1:0] OFS_T_RRD     = 8'h84;
    localparam logic [CSR_DEC_W-1:0] OFS_T_WRP     = 8'h88;
    localparam logic [CSR_DEC_W-1:0] OFS_T_XSR     = 8'h8c;
    localparam logic [CSR_DEC_W-1:0] OFS_T_MRD     = 8'hb8;

    // ----------------------------------------
    // Slave to bank access word
    // ----------------------------------------
    typedef struct packed {
        logic      wr_en;                       // One-cycle write strobe
        csr_addr_t addr;                        // Full bus address
        csr_data_t wdata;                       // Write payload
    } csr_access_t;

endpackage

/* design/sdram_timing_pkg.sv */
/*
 * SDRAM device-side definitions
 * Control and mode-register field layouts, timing counter widths
 * and reset defaults derived from datasheet figures.
 */

package sdram_timing_pkg;

    // ----------------------------------------
    // Clock and conversion helpers
    // ----------------------------------------
    localparam int TCLK_PS = 10000;             // 100 MHz controller clock

    function automatic int ceil_div(input int num, input int den);
        return num / den + ((num % den != 0) ? 1 : 0);
    endfunction

    // Minimum times round up so the spec is never violated
    function automatic int ns2ck_min(input int value_ps);
        return ceil_div(value_ps, TCLK_PS);
    endfunction

    // Maximum times round down
    function automatic int ns2ck_max(input int value_ps);
        return value_ps / TCLK_PS;
    endfunction

    function automatic int ns2ck_min_bounded(input int value_ps, input int min_val);
        int cycles;
        cycles = ceil_div(value_ps, TCLK_PS);
        return (cycles > min_val) ? cycles : min_val;
    endfunction

    // ----------------------------------------
    // Field widths and types
    // ----------------------------------------
    localparam int CNT_LONG_W  = 20;            // Power-up delay and refresh period
    localparam int CNT_W       = 8;
    localparam int CNT_WRP_W   = 2;
    localparam int CNT_SHORT_W = 4;

    typedef logic [CNT_LONG_W-1:0]  cnt_long_t;
    typedef logic [CNT_W-1:0]       cnt_t;
    typedef logic [CNT_WRP_W-1:0]   cnt_wrp_t;
    typedef logic [CNT_SHORT_W-1:0] cnt_short_t;

    typedef struct packed {
        logic load_mode_register;
        logic self_refresh;
        logic start;                            // Bit 0
    } csr_ctrl_t;

    typedef struct packed {
        logic [1:0] ba_reserved;
        logic [2:0] a_reserved;
        logic       wr_burst_mode;
        logic [1:0] operation_mode;
        logic [2:0] cas_latency;
        logic       burst_type;
        logic [2:0] burst_len;
    } opmode_fields_t;

    // Software sees the raw image, the sequencer uses the fields
    typedef union packed {
        logic [14:0]    raw;
        opmode_fields_t f;
    } csr_opmode_u;

    typedef struct packed {
        cnt_long_t  dly_rst;
        cnt_t       rasmin;
        cnt_t       rc;
        cnt_t       rcd;
        cnt_long_t  refresh;
        cnt_t       rfc;
        cnt_t       rp;
        cnt_t       rrd;
        cnt_wrp_t   wrp;
        cnt_t       xsr;
        cnt_short_t mrd;
    } sdram_timing_t;

    // ----------------------------------------
    // Reset defaults from figures in ps
    // ----------------------------------------
    localparam sdram_timing_t TIMING_DEFAULT = '{
        dly_rst: cnt_long_t'(ns2ck_min(100_000_000)),   // Power-up wait before commands
        rasmin:  cnt_t'(ns2ck_min(37000)),              // ACTIVE to PRECHARGE
        rc:      cnt_t'(ns2ck_min(60000)),              // ACTIVE to ACTIVE, same bank
        rcd:     cnt_t'(ns2ck_min(15000)),              // ACTIVE to READ or WRITE
        refresh: cnt_long_t'(ns2ck_max(64_000_000)),    // Refresh interval
        rfc:     cnt_t'(ns2ck_min(66000)),              // AUTO REFRESH period
        rp:      cnt_t'(ns2ck_min(15000)),              // PRECHARGE period
        rrd:     cnt_t'(ns2ck_min(14000)),              // ACTIVE bank a to bank b
        wrp:     cnt_wrp_t'(ns2ck_min(14000)),          // Write recovery
        xsr:     cnt_t'(ns2ck_min_bounded(67000, 2)),   // Self refresh exit
        mrd:     cnt_short_t'(2)                        // LMR to next command
    };

endpackage

/* design/csr_bus_slave.sv */
/*
 * CSR bus slave
 * Turns strobe/cycle into a single access, pulses the write strobe
 * and returns a one-cycle ack with registered read data.
 */

module csr_bus_slave (
    input  logic                      clk,
    input  logic                      reset,

    input  sdram_csr_pkg::csr_addr_t  wbs_address,
    input  sdram_csr_pkg::csr_data_t  wbs_writedata,
    input  logic                      wbs_write,
    input  logic                      wbs_strobe,
    input  logic                      wbs_cycle,

    input  sdram_csr_pkg::csr_data_t  mode_rdata,
    input  sdram_csr_pkg::csr_data_t  timing_rdata,

    output sdram_csr_pkg::csr_access_t access,
    output sdram_csr_pkg::csr_data_t  wbs_readdata,
    output logic                      wbs_ack
);

    logic trans;
    logic trans_dly;
    logic start;

    // ----------------------------------------
    // Transaction start detect
    // ----------------------------------------
    assign trans = wbs_strobe & wbs_cycle;
    assign start = trans & ~trans_dly;          // Held strobe counts once

    assign access.wr_en = start & wbs_write;
    assign access.addr  = wbs_address;
    assign access.wdata = wbs_writedata;

    // ----------------------------------------
    // Ack and read data
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trans_dly    <= 1'b0;
            wbs_ack      <= 1'b0;
            wbs_readdata <= '0;
        end else begin
            trans_dly <= trans;
            wbs_ack   <= start;
            if (start & ~wbs_write) begin
                wbs_readdata <= mode_rdata | timing_rdata;  // Banks return zero when not hit
            end else begin
                wbs_readdata <= '0;
            end
        end
    end

    // Ack is a single-cycle pulse per transaction
    ack_single_pulse: assert property (
        @(posedge clk) disable iff (reset) wbs_ack |=> !wbs_ack
    );

endmodule

/* design/csr_mode_regs.sv */
/*
 * Mode register bank
 * Control bits, SDRAM mode-register image and config bit,
 * with write decode and zero-extended readback.
 */

module csr_mode_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  sdram_csr_pkg::csr_access_t  access,
    output sdram_csr_pkg::csr_data_t    rdata,
    output sdram_timing_pkg::csr_ctrl_t csr_ctrl,
    output sdram_timing_pkg::csr_opmode_u csr_opmode,
    output logic                        csr_prechg_after_rd
);

    localparam int CTRL_W   = $bits(sdram_timing_pkg::csr_ctrl_t);
    localparam int OPMODE_W = $bits(sdram_timing_pkg::csr_opmode_u);

    logic [sdram_csr_pkg::CSR_DEC_W-1:0] ofs;
    logic ctrl_wr;
    logic opmode_wr;
    logic config_wr;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------
    assign ofs       = access.addr[sdram_csr_pkg::CSR_DEC_W-1:0];
    assign ctrl_wr   = access.wr_en && (ofs == sdram_csr_pkg::OFS_CTRL);
    assign opmode_wr = access.wr_en && (ofs == sdram_csr_pkg::OFS_OPMODE);
    assign config_wr = access.wr_en && (ofs == sdram_csr_pkg::OFS_CONFIG);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            csr_ctrl            <= '0;
            csr_opmode          <= '0;
            csr_prechg_after_rd <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                csr_ctrl <= access.wdata[CTRL_W-1:0];
            end
            if (opmode_wr) begin
                csr_opmode.raw <= access.wdata[OPMODE_W-1:0];   // Upper bits dropped
            end
            if (config_wr) begin
                csr_prechg_after_rd <= access.wdata[0];
            end
        end
    end

    // ----------------------------------------
    // Readback
    // ----------------------------------------
    always_comb begin
        rdata = '0;
        case (ofs)
            sdram_csr_pkg::OFS_CTRL:   rdata[CTRL_W-1:0]   = csr_ctrl;
            sdram_csr_pkg::OFS_OPMODE: rdata[OPMODE_W-1:0] = csr_opmode.raw;
            sdram_csr_pkg::OFS_CONFIG: rdata[0]            = csr_prechg_after_rd;
            default:                   rdata               = '0;
        endcase
    end

    // Burst length only moves to a value software wrote
    burst_len_from_write: assert property (
        @(posedge clk) disable iff (reset)
        (csr_opmode.f.burst_len != $past(csr_opmode.f.burst_len)) |->
            ($past(opmode_wr) && ($past(access.wdata[2:0]) == csr_opmode.f.burst_len))
    );

endmodule

/* design/csr_timing_regs.sv */
/*
 * Timing register bank
 * Command-to-command cycle counts for the sequencer, reset to
 * datasheet-derived defaults and truncated to field width on write.
 */

module csr_timing_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  sdram_csr_pkg::csr_access_t      access,
    output sdram_csr_pkg::csr_data_t        rdata,
    output sdram_timing_pkg::sdram_timing_t csr_timing
);

    localparam int LW = sdram_timing_pkg::CNT_LONG_W;
    localparam int NW = sdram_timing_pkg::CNT_W;
    localparam int WW = sdram_timing_pkg::CNT_WRP_W;
    localparam int SW = sdram_timing_pkg::CNT_SHORT_W;

    logic [sdram_csr_pkg::CSR_DEC_W-1:0] ofs;

    assign ofs = access.addr[sdram_csr_pkg::CSR_DEC_W-1:0];

    // ----------------------------------------
    // Count registers
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            csr_timing <= sdram_timing_pkg::TIMING_DEFAULT;
        end else if (access.wr_en) begin
            case (ofs)
                sdram_csr_pkg::OFS_T_DLY_RST: csr_timing.dly_rst <= access.wdata[LW-1:0];
                sdram_csr_pkg::OFS_T_RASMIN:  csr_timing.rasmin  <= access.wdata[NW-1:0];
                sdram_csr_pkg::OFS_T_RC:      csr_timing.rc      <= access.wdata[NW-1:0];
                sdram_csr_pkg::OFS_T_RCD:     csr_timing.rcd     <= access.wdata[NW-1:0];
                sdram_csr_pkg::OFS_T_REF:     csr_timing.refresh <= access.wdata[LW-1:0];
                sdram_csr_pkg::OFS_T_RFC:     csr_timing.rfc     <= access.wdata[NW-1:0];
                sdram_csr_pkg::OFS_T_RP:      csr_timing.rp      <= access.wdata[NW-1:0];
                sdram_csr_pkg::OFS_T_RRD:     csr_timing.rrd     <= access.wdata[NW-1:0];
                sdram_csr_pkg::OFS_T_WRP:     csr_timing.wrp     <= access.wdata[WW-1:0];
                sdram_csr_pkg::OFS_T_XSR:     csr_timing.xsr     <= access.wdata[NW-1:0];
                sdram_csr_pkg::OFS_T_MRD:     csr_timing.mrd     <= access.wdata[SW-1:0];
                default: ;                      // Mode bank or unmapped offset
            endcase
        end
    end

    // ----------------------------------------
    // Zero-extended readback
    // ----------------------------------------
    always_comb begin
        rdata = '0;
        case (ofs)
            sdram_csr_pkg::OFS_T_DLY_RST: rdata[LW-1:0] = csr_timing.dly_rst;
            sdram_csr_pkg::OFS_T_RASMIN:  rdata[NW-1:0] = csr_timing.rasmin;
            sdram_csr_pkg::OFS_T_RC:      rdata[NW-1:0] = csr_timing.rc;
            sdram_csr_pkg::OFS_T_RCD:     rdata[NW-1:0] = csr_timing.rcd;
            sdram_csr_pkg::OFS_T_REF:     rdata[LW-1:0] = csr_timing.refresh;
            sdram_csr_pkg::OFS_T_RFC:     rdata[NW-1:0] = csr_timing.rfc;
            sdram_csr_pkg::OFS_T_RP:      rdata[NW-1:0] = csr_timing.rp;
            sdram_csr_pkg::OFS_T_RRD:     rdata[NW-1:0] = csr_timing.rrd;
            sdram_csr_pkg::OFS_T_WRP:     rdata[WW-1:0] = csr_timing.wrp;
            sdram_csr_pkg::OFS_T_XSR:     rdata[NW-1:0] = csr_timing.xsr;
            sdram_csr_pkg::OFS_T_MRD:     rdata[SW-1:0] = csr_timing.mrd;
            default:                      rdata         = '0;
        endcase
    end

    // First edge out of reset still sees the datasheet defaults
    defaults_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> (csr_timing == sdram_timing_pkg::TIMING_DEFAULT)
    );

endmodule

/* design/sdram_csr.sv */
/*
 * SDRAM controller register block
 * Bus slave plus mode and timing register banks.
 */

module sdram_csr (
    input  logic                            clk,
    input  logic                            reset,

    // Bus
    input  sdram_csr_pkg::csr_addr_t        wbs_address,
    input  sdram_csr_pkg::csr_data_t        wbs_writedata,
    input  logic                            wbs_write,
    input  logic                            wbs_strobe,
    input  logic                            wbs_cycle,
    output sdram_csr_pkg::csr_data_t        wbs_readdata,
    output logic                            wbs_ack,

    // To the sequencer
    output sdram_timing_pkg::csr_ctrl_t     csr_ctrl,
    output sdram_timing_pkg::csr_opmode_u   csr_opmode,
    output logic                            csr_prechg_after_rd,
    output sdram_timing_pkg::sdram_timing_t csr_timing
);

    sdram_csr_pkg::csr_access_t access;
    sdram_csr_pkg::csr_data_t   mode_rdata;
    sdram_csr_pkg::csr_data_t   timing_rdata;

    csr_bus_slave u_bus_slave (
        .clk           (clk),
        .reset         (reset),
        .wbs_address   (wbs_address),
        .wbs_writedata (wbs_writedata),
        .wbs_write     (wbs_write),
        .wbs_strobe    (wbs_strobe),
        .wbs_cycle     (wbs_cycle),
        .mode_rdata    (mode_rdata),
        .timing_rdata  (timing_rdata),
        .access        (access),
        .wbs_readdata  (wbs_readdata),
        .wbs_ack       (wbs_ack)
    );

    csr_mode_regs u_mode_regs (
        .clk                 (clk),
        .reset               (reset),
        .access              (access),
        .rdata               (mode_rdata),
        .csr_ctrl            (csr_ctrl),
        .csr_opmode          (csr_opmode),
        .csr_prechg_after_rd (csr_prechg_after_rd)
    );

    csr_timing_regs u_timing_regs (
        .clk        (clk),
        .reset      (reset),
        .access     (access),
        .rdata      (timing_rdata),
        .csr_timing (csr_timing)
    );

endmodule

/* tests/sdram_csr_tb.sv */
/*
 * SDRAM CSR testbench
 * Directed tests of reset values, register access, address decode
 * and bus protocol, checked against a shadow model of the registers.
 */

module sdram_csr_tb;

    logic                            clk;
    logic                            reset;
    sdram_csr_pkg::csr_addr_t        wbs_address;
    sdram_csr_pkg::csr_data_t        wbs_writedata;
    logic                            wbs_write;
    logic                            wbs_strobe;
    logic                            wbs_cycle;
    sdram_csr_pkg::csr_data_t        wbs_readdata;
    logic                            wbs_ack;
    sdram_timing_pkg::csr_ctrl_t     csr_ctrl;
    sdram_timing_pkg::csr_opmode_u   csr_opmode;
    logic                            csr_prechg_after_rd;
    sdram_timing_pkg::sdram_timing_t csr_timing;

    logic [7:0]               kept_ofs [14];    // Every implemented offset
    int                       kept_w   [14];    // Defined bits per offset
    sdram_csr_pkg::csr_data_t shadow   [14];    // Expected readback per offset
    logic [31:0]              lcg_state;
    int                       cycle_count;

    sdram_csr UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // Failure handling and compare tasks
    // ----------------------------------------
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input sdram_csr_pkg::csr_data_t got,
                              input sdram_csr_pkg::csr_data_t exp);
        if (got !== exp) begin
            $display("error @%0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input sdram_timing_pkg::csr_ctrl_t got,
                              input sdram_timing_pkg::csr_ctrl_t exp);
        if (got !== exp) begin
            $display("error @%0t: csr_ctrl is %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_opmode(input sdram_timing_pkg::csr_opmode_u got,
                                input sdram_timing_pkg::csr_opmode_u exp);
        if (got !== exp) begin
            $display("error @%0t: csr_opmode is 0x%04h, expected 0x%04h", $time,
                     got.raw, exp.raw);
            abort_run();
        end
    endtask

    task automatic check_timing(input sdram_timing_pkg::sdram_timing_t got,
                                input sdram_timing_pkg::sdram_timing_t exp);
        if (got !== exp) begin
            $display("error @%0t: csr_timing is 0x%h, expected 0x%h", $time, got, exp);
            abort_run();
        end
    endtask

    // Cycle limit and idle read data watch
    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 2000) begin
            $display("Timeout: tests still running after 2000 clock cycles");
            abort_run();
        end
        if (!reset && !wbs_ack) begin
            check_word("wbs_readdata outside ack", wbs_readdata, '0);
        end
    end

    // ----------------------------------------
    // Stimulus and shadow model
    // ----------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // 10 ns clock, minimum times round up
    function automatic int clocks_min(input int ns);
        return (ns + 9) / 10;
    endfunction

    function automatic int clocks_max(input int ns);
        return ns / 10;                         // Maximum times round down
    endfunction

    task automatic load_shadow_defaults();
        kept_ofs = '{8'h00, 8'h04, 8'h08, 8'h20, 8'h64, 8'h6c, 8'h70,
                     8'h74, 8'h78, 8'h80, 8'h84, 8'h88, 8'h8c, 8'hb8};
        kept_w   = '{3, 15, 1, 20, 8, 8, 8, 20, 8, 8, 8, 2, 8, 4};
        shadow   = '{0, 0, 0, clocks_min(100000), clocks_min(37), clocks_min(60),
                     clocks_min(15), clocks_max(64000), clocks_min(66), clocks_min(15),
                     clocks_min(14), clocks_min(14), clocks_min(67), 2};
    endtask

    function automatic void model_write(input sdram_csr_pkg::csr_addr_t addr,
                                        input logic [31:0] data);
        for (int i = 0; i < 14; i++) begin
            if (kept_ofs[i] == addr[7:0]) begin
                shadow[i] = data & ((32'd1 << kept_w[i]) - 32'd1);
            end
        end
    endfunction

    function automatic sdram_csr_pkg::csr_data_t model_read(input sdram_csr_pkg::csr_addr_t addr);
        sdram_csr_pkg::csr_data_t r;
        r = '0;
        for (int i = 0; i < 14; i++) begin
            if (kept_ofs[i] == addr[7:0]) begin
                r = shadow[i];
            end
        end
        return r;
    endfunction

    // Outputs rebuilt field by field from the shadow words
    task automatic check_outputs();
        sdram_timing_pkg::csr_ctrl_t     ctrl;
        sdram_timing_pkg::csr_opmode_u   opmode;
        sdram_timing_pkg::sdram_timing_t timing;
        ctrl     = '{shadow[0][2], shadow[0][1], shadow[0][0]};
        opmode.f = '{shadow[1][14:13], shadow[1][12:10], shadow[1][9], shadow[1][8:7],
                     shadow[1][6:4], shadow[1][3], shadow[1][2:0]};
        timing   = '{shadow[3][19:0], shadow[4][7:0], shadow[5][7:0], shadow[6][7:0],
                     shadow[7][19:0], shadow[8][7:0], shadow[9][7:0], shadow[10][7:0],
                     shadow[11][1:0], shadow[12][7:0], shadow[13][3:0]};
        check_ctrl(csr_ctrl, ctrl);
        check_opmode(csr_opmode, opmode);
        check_word("csr_prechg_after_rd", 32'(csr_prechg_after_rd), shadow[2]);
        check_timing(csr_timing, timing);
    endtask

    // ----------------------------------------
    // Bus transactions
    // ----------------------------------------
    task automatic bus_access(input sdram_csr_pkg::csr_addr_t addr, input logic [31:0] data,
                              input logic write, output sdram_csr_pkg::csr_data_t rdata);
        int waited;
        @(negedge clk);
        {wbs_address, wbs_writedata, wbs_write, wbs_strobe, wbs_cycle} = {addr, data, write, 2'b11};
        waited = 1;
        @(negedge clk);
        while (!wbs_ack) begin
            if (waited >= 2) begin
                $display("No ack within 2 cycles of strobe at address 0x%04h", addr);
                abort_run();
            end
            waited++;
            @(negedge clk);
        end
        rdata = wbs_readdata;                   // Sampled in the ack cycle
        {wbs_address, wbs_writedata, wbs_write, wbs_strobe, wbs_cycle} = '0;
    endtask

    task automatic bus_write(input sdram_csr_pkg::csr_addr_t addr, input logic [31:0] data);
        sdram_csr_pkg::csr_data_t rdata;
        bus_access(addr, data, 1'b1, rdata);
        check_word("wbs_readdata in write ack", rdata, '0);
        model_write(addr, data);
        check_outputs();                        // New value visible during ack
    endtask

    task automatic bus_read(input sdram_csr_pkg::csr_addr_t addr,
                            output sdram_csr_pkg::csr_data_t rdata);
        bus_access(addr, 32'd0, 1'b0, rdata);
    endtask

    task automatic read_check(input sdram_csr_pkg::csr_addr_t addr);
        sdram_csr_pkg::csr_data_t got;
        bus_read(addr, got);
        check_word($sformatf("read at 0x%04h", addr), got, model_read(addr));
    endtask

    task automatic verify_readback();
        for (int i = 0; i < 14; i++) begin
            read_check({8'h00, kept_ofs[i]});
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_values();
        check_word("wbs_ack after reset", 32'(wbs_ack), '0);
        check_outputs();
        verify_readback();
    endtask

    task automatic test_mode_regs();
        for (int n = 0; n < 4; n++) begin
            bus_write(16'h0000, next_random());
            bus_write(16'h0004, next_random());
            bus_write(16'h0008, next_random());
            read_check(16'h0000);
            read_check(16'h0004);
            read_check(16'h0008);
            check_outputs();                    // Still held after ack
        end
    endtask

    task automatic test_timing_regs();
        for (int i = 3; i < 14; i++) begin
            bus_write({8'h00, kept_ofs[i]}, next_random());
            read_check({8'h00, kept_ofs[i]});
        end
    endtask

    task automatic test_unmapped();
        sdram_csr_pkg::csr_data_t got;
        logic [15:0]              holes [3];
        holes = '{16'h000c, 16'h0024, 16'h00c4};
        foreach (holes[i]) begin
            bus_read(holes[i], got);
            check_word($sformatf("read at unmapped 0x%04h", holes[i]), got, '0);
            bus_write(holes[i], next_random());
        end
        verify_readback();
        bus_write(16'h3470, next_random());     // Alias of t_rcd
        read_check(16'h5a70);
        bus_write(16'h1204, next_random());     // Alias of opmode
        read_check(16'hff04);
    endtask

    task automatic test_bus_protocol();
        logic [31:0] first;
        int          acks;
        first = next_random();
        acks  = 0;
        @(negedge clk);
        {wbs_address, wbs_writedata, wbs_write, wbs_strobe, wbs_cycle} = {16'h006c, first, 3'b111};
        repeat (5) begin
            @(negedge clk);
            wbs_writedata = ~first;             // Lands only if a second write occurs
            if (wbs_ack) acks++;
        end
        {wbs_address, wbs_writedata, wbs_write, wbs_strobe, wbs_cycle} = '0;
        repeat (2) begin
            @(negedge clk);
            if (wbs_ack) acks++;
        end
        check_word("acks for held strobe", 32'(acks), 32'd1);
        model_write(16'h006c, first);
        check_outputs();
        read_check(16'h006c);

        // Strobe with cycle low
        acks = 0;
        @(negedge clk);
        {wbs_address, wbs_writedata, wbs_write, wbs_strobe, wbs_cycle} = {16'h0000, ~shadow[0], 3'b110};
        repeat (4) begin
            @(negedge clk);
            if (wbs_ack) acks++;
        end
        {wbs_address, wbs_writedata, wbs_write, wbs_strobe, wbs_cycle} = '0;
        check_word("acks with cycle low", 32'(acks), 32'd0);
        check_outputs();
        read_check(16'h0000);
    endtask

    initial begin
        reset = 1'b1;
        {wbs_address, wbs_writedata, wbs_write, wbs_strobe, wbs_cycle} = '0;
        lcg_state = 32'd71;
        load_shadow_defaults();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_values();
        test_mode_regs();
        test_timing_regs();
        test_unmapped();
        test_bus_protocol();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* project.f */
design/sdram_csr_pkg.sv
design/sdram_timing_pkg.sv
design/csr_bus_slave.sv
design/csr_mode_regs.sv
design/csr_timing_regs.sv
design/sdram_csr.sv
tests/sdram_csr_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = sdram_csr_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

SRCS = $(wildcard design/*.sv) $(wildcard tests/*.sv)
SIM  = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Run did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
